//--- Bender.yml
package:
  name: lc4_superscalar

sources:
  - lc4_pkg.sv
  - lc4_decoder.sv
  - lc4_alu.sv
  - lc4_regfile_dual.sv
  - lc4_bypass.sv
  - lc4_issue_ctrl.sv
  - lc4_exec_pipe.sv
  - lc4_superscalar.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tb_lc4_superscalar.sv

//--- compile.f
lc4_pkg.sv
lc4_decoder.sv
lc4_alu.sv
lc4_regfile_dual.sv
lc4_bypass.sv
lc4_issue_ctrl.sv
lc4_exec_pipe.sv
lc4_superscalar.sv
tb_clock.sv
tb_lc4_superscalar.sv

//--- lc4_alu.sv
module lc4_alu (
   input  lc4_pkg::alu_op_e i_op,
   input  lc4_pkg::word_t   i_a,
   input  lc4_pkg::word_t   i_b,
   input  lc4_pkg::word_t   i_imm,
   input  logic             i_use_imm,
   output lc4_pkg::word_t   o_result
);

   lc4_pkg::word_t opnd_b;

   // immediate forms have no rt
   assign opnd_b = i_use_imm ? i_imm : i_b;

   always_comb begin
      case (i_op)
         lc4_pkg::ALU_ADD:      o_result = i_a + opnd_b;
         lc4_pkg::ALU_SUB:      o_result = i_a - opnd_b;
         lc4_pkg::ALU_AND:      o_result = i_a & opnd_b;
         lc4_pkg::ALU_OR:       o_result = i_a | opnd_b;
         lc4_pkg::ALU_PASS_IMM: o_result = i_imm;  // CONST
         default:               o_result = '0;
      endcase
   end

endmodule

//--- lc4_bypass.sv
module lc4_bypass (
   input  lc4_pkg::reg_sel_t i_rs_a,
   input  lc4_pkg::reg_sel_t i_rt_a,
   input  logic              i_rs_re_a,
   input  logic              i_rt_re_a,
   input  lc4_pkg::reg_sel_t i_rs_b,
   input  lc4_pkg::reg_sel_t i_rt_b,
   input  logic              i_rs_re_b,
   input  logic              i_rt_re_b,
   input  lc4_pkg::reg_sel_t i_m_rd_a,
   input  lc4_pkg::reg_sel_t i_m_rd_b,
   input  logic              i_m_we_a,
   input  logic              i_m_we_b,
   input  lc4_pkg::word_t    i_m_data_a,
   input  lc4_pkg::word_t    i_m_data_b,
   input  lc4_pkg::reg_sel_t i_w_rd_a,
   input  lc4_pkg::reg_sel_t i_w_rd_b,
   input  logic              i_w_we_a,
   input  logic              i_w_we_b,
   input  lc4_pkg::word_t    i_w_data_a,
   input  lc4_pkg::word_t    i_w_data_b,
   input  lc4_pkg::word_t    i_rs_data_a,
   input  lc4_pkg::word_t    i_rt_data_a,
   input  lc4_pkg::word_t    i_rs_data_b,
   input  lc4_pkg::word_t    i_rt_data_b,
   output lc4_pkg::word_t    o_op1_a,
   output lc4_pkg::word_t    o_op2_a,
   output lc4_pkg::word_t    o_op1_b,
   output lc4_pkg::word_t    o_op2_b
);

   // youngest producer first: M before W, lane b before lane a
   function automatic lc4_pkg::word_t pick(input lc4_pkg::reg_sel_t sel,
                                           input logic              re,
                                           input lc4_pkg::word_t    rf_val);
      if (!re) return rf_val;
      if (i_m_we_b && i_m_rd_b == sel) return i_m_data_b;  // MX
      if (i_m_we_a && i_m_rd_a == sel) return i_m_data_a;
      if (i_w_we_b && i_w_rd_b == sel) return i_w_data_b;  // WX
      if (i_w_we_a && i_w_rd_a == sel) return i_w_data_a;
      return rf_val;
   endfunction

   always_comb begin
      o_op1_a = pick(i_rs_a, i_rs_re_a, i_rs_data_a);
      o_op2_a = pick(i_rt_a, i_rt_re_a, i_rt_data_a);
      o_op1_b = pick(i_rs_b, i_rs_re_b, i_rs_data_b);
      o_op2_b = pick(i_rt_b, i_rt_re_b, i_rt_data_b);
   end

endmodule

//--- lc4_cases.txt
# P <addr> <insn>              program word, hex
# E <pc> <rd> <data> <same>    retire in program order, same=1 retires with the previous entry
P 8200 9207  # const r1, 7
P 8201 95FD  # const r2, -3
P 8202 9700  # const r3, -256
P 8203 98FF  # const r4, 255
P 8204 1A42  # add r5, r1, r2
P 8205 1D13  # sub r6, r4, r3
P 8206 5F83  # and r7, r6, r3
P 8207 51D1  # or r0, r7, r1 splits
P 8208 143F  # add r0 imm -1 into r2, splits
P 8209 57B0  # and r3, r6, -16
P 820A 9864  # const r4, 100
P 820B 999C  # const r4, -100 wins
P 820C 1B04  # add r5, r4, r4
P 820D 1293  # sub r1, r2, r3
P 820E 91FF  # const r0, -1
P 820F 5E45  # and r7, r1, r5
P 8210 5D12  # or r6, r4, r2
P 8211 1607  # add r3, r0, r7
P 8212 1393  # sub r1, r6, r3
P 8213 1461  # add r2, r1, 1 splits
E 8200 1 0007 0
E 8201 2 FFFD 1
E 8202 3 FF00 0
E 8203 4 00FF 1
E 8204 5 0004 0
E 8205 6 01FF 1
E 8206 7 0100 0
E 8207 0 0107 0
E 8208 2 0106 0
E 8209 3 01F0 1
E 820A 4 0064 0
E 820B 4 FF9C 1
E 820C 5 FF38 0
E 820D 1 FF16 1
E 820E 0 FFFF 0
E 820F 7 FF10 1
E 8210 6 FF9E 0
E 8211 3 FF0F 1
E 8212 1 008F 0
E 8213 2 0090 0

//--- lc4_decoder.sv
module lc4_decoder (
   input  lc4_pkg::word_t    i_insn,
   output lc4_pkg::reg_sel_t o_rs,
   output lc4_pkg::reg_sel_t o_rt,
   output lc4_pkg::reg_sel_t o_rd,
   output logic              o_rs_re,
   output logic              o_rt_re,
   output logic              o_rd_we,
   output lc4_pkg::alu_op_e  o_alu_op,
   output lc4_pkg::word_t    o_imm
);

   lc4_pkg::opcode_e opcode;
   logic [2:0]       sub_op;

   assign opcode = lc4_pkg::opcode_e'(i_insn[15:12]);
   assign sub_op = i_insn[5:3];

   // field positions are fixed across the kept formats
   assign o_rd = i_insn[11:9];
   assign o_rs = i_insn[8:6];
   assign o_rt = i_insn[2:0];

   always_comb begin
      o_rs_re  = 1'b0;
      o_rt_re  = 1'b0;
      o_rd_we  = 1'b0;
      o_alu_op = lc4_pkg::ALU_ADD;
      o_imm    = {{11{i_insn[4]}}, i_insn[4:0]};  // imm5 by default

      case (opcode)
         lc4_pkg::OP_ARITH: begin
            if (i_insn[5]) begin  // ADD imm5
               o_rs_re = 1'b1;
               o_rd_we = 1'b1;
            end else if (sub_op == 3'b000 || sub_op == 3'b010) begin
               o_rs_re  = 1'b1;
               o_rt_re  = 1'b1;
               o_rd_we  = 1'b1;
               o_alu_op = (sub_op == 3'b010) ? lc4_pkg::ALU_SUB : lc4_pkg::ALU_ADD;
            end
         end
         lc4_pkg::OP_LOGIC: begin
            o_alu_op = lc4_pkg::ALU_AND;
            if (i_insn[5]) begin  // AND imm5
               o_rs_re = 1'b1;
               o_rd_we = 1'b1;
            end else if (sub_op == 3'b000 || sub_op == 3'b010) begin
               o_rs_re  = 1'b1;
               o_rt_re  = 1'b1;
               o_rd_we  = 1'b1;
               o_alu_op = (sub_op == 3'b010) ? lc4_pkg::ALU_OR : lc4_pkg::ALU_AND;
            end
         end
         lc4_pkg::OP_CONST: begin
            o_rd_we  = 1'b1;
            o_alu_op = lc4_pkg::ALU_PASS_IMM;
            o_imm    = {{7{i_insn[8]}}, i_insn[8:0]};  // imm9
         end
         default: ;  // NOP and anything unsupported write nothing
      endcase
   end

endmodule

//--- lc4_exec_pipe.sv
module lc4_exec_pipe (
   input  logic              gwe,
   input  logic              i_rst,
   input  logic              i_issue_a,
   input  lc4_pkg::word_t    i_pc_a,
   input  lc4_pkg::reg_sel_t i_rs_a,
   input  lc4_pkg::reg_sel_t i_rt_a,
   input  logic              i_rs_re_a,
   input  logic              i_rt_re_a,
   input  lc4_pkg::reg_sel_t i_rd_a,
   input  logic              i_rd_we_a,
   input  lc4_pkg::alu_op_e  i_alu_op_a,
   input  lc4_pkg::word_t    i_imm_a,
   input  logic              i_issue_b,
   input  lc4_pkg::word_t    i_pc_b,
   input  lc4_pkg::reg_sel_t i_rs_b,
   input  lc4_pkg::reg_sel_t i_rt_b,
   input  logic              i_rs_re_b,
   input  logic              i_rt_re_b,
   input  lc4_pkg::reg_sel_t i_rd_b,
   input  logic              i_rd_we_b,
   input  lc4_pkg::alu_op_e  i_alu_op_b,
   input  lc4_pkg::word_t    i_imm_b,
   input  lc4_pkg::word_t    i_rs_data_a,
   input  lc4_pkg::word_t    i_rt_data_a,
   input  lc4_pkg::word_t    i_rs_data_b,
   input  lc4_pkg::word_t    i_rt_data_b,
   output logic              o_wb_we_a,
   output lc4_pkg::reg_sel_t o_wb_rd_a,
   output lc4_pkg::word_t    o_wb_data_a,
   output lc4_pkg::word_t    o_wb_pc_a,
   output logic              o_wb_we_b,
   output lc4_pkg::reg_sel_t o_wb_rd_b,
   output lc4_pkg::word_t    o_wb_data_b,
   output lc4_pkg::word_t    o_wb_pc_b
);

   // X stage
   logic              x_we_a, x_we_b;
   logic              x_rs_re_a, x_rt_re_a, x_rs_re_b, x_rt_re_b;
   lc4_pkg::reg_sel_t x_rs_a, x_rt_a, x_rd_a, x_rs_b, x_rt_b, x_rd_b;
   lc4_pkg::alu_op_e  x_op_a, x_op_b;
   lc4_pkg::word_t    x_pc_a, x_imm_a, x_rs_data_a, x_rt_data_a;
   lc4_pkg::word_t    x_pc_b, x_imm_b, x_rs_data_b, x_rt_data_b;
   lc4_pkg::word_t    op1_a, op2_a, op1_b, op2_b;
   lc4_pkg::word_t    alu_res_a, alu_res_b;
   // M stage
   logic              m_we_a, m_we_b;
   lc4_pkg::reg_sel_t m_rd_a, m_rd_b;
   lc4_pkg::word_t    m_data_a, m_data_b, m_pc_a, m_pc_b;

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         x_we_a    <= 1'b0;
         x_we_b    <= 1'b0;
         m_we_a    <= 1'b0;
         m_we_b    <= 1'b0;
         o_wb_we_a <= 1'b0;
         o_wb_we_b <= 1'b0;
      end else begin
         x_we_a    <= i_issue_a && i_rd_we_a;  // no issue means bubble
         x_we_b    <= i_issue_b && i_rd_we_b;
         m_we_a    <= x_we_a;
         m_we_b    <= x_we_b;
         o_wb_we_a <= m_we_a;
         o_wb_we_b <= m_we_b;
      end
   end

   always_ff @(posedge gwe) begin
      x_pc_a      <= i_pc_a;
      x_rs_a      <= i_rs_a;
      x_rt_a      <= i_rt_a;
      x_rs_re_a   <= i_rs_re_a;
      x_rt_re_a   <= i_rt_re_a;
      x_rd_a      <= i_rd_a;
      x_op_a      <= i_alu_op_a;
      x_imm_a     <= i_imm_a;
      x_rs_data_a <= i_rs_data_a;
      x_rt_data_a <= i_rt_data_a;
      x_pc_b      <= i_pc_b;
      x_rs_b      <= i_rs_b;
      x_rt_b      <= i_rt_b;
      x_rs_re_b   <= i_rs_re_b;
      x_rt_re_b   <= i_rt_re_b;
      x_rd_b      <= i_rd_b;
      x_op_b      <= i_alu_op_b;
      x_imm_b     <= i_imm_b;
      x_rs_data_b <= i_rs_data_b;
      x_rt_data_b <= i_rt_data_b;
      m_rd_a      <= x_rd_a;
      m_rd_b      <= x_rd_b;
      m_data_a    <= alu_res_a;
      m_data_b    <= alu_res_b;
      m_pc_a      <= x_pc_a;
      m_pc_b      <= x_pc_b;
      o_wb_rd_a   <= m_rd_a;
      o_wb_rd_b   <= m_rd_b;
      o_wb_data_a <= m_data_a;
      o_wb_data_b <= m_data_b;
      o_wb_pc_a   <= m_pc_a;
      o_wb_pc_b   <= m_pc_b;
   end

   lc4_bypass bypass_i (
      .i_rs_a      (x_rs_a),      .i_rt_a      (x_rt_a),
      .i_rs_re_a   (x_rs_re_a),   .i_rt_re_a   (x_rt_re_a),
      .i_rs_b      (x_rs_b),      .i_rt_b      (x_rt_b),
      .i_rs_re_b   (x_rs_re_b),   .i_rt_re_b   (x_rt_re_b),
      .i_m_rd_a    (m_rd_a),      .i_m_rd_b    (m_rd_b),
      .i_m_we_a    (m_we_a),      .i_m_we_b    (m_we_b),
      .i_m_data_a  (m_data_a),    .i_m_data_b  (m_data_b),
      .i_w_rd_a    (o_wb_rd_a),   .i_w_rd_b    (o_wb_rd_b),
      .i_w_we_a    (o_wb_we_a),   .i_w_we_b    (o_wb_we_b),
      .i_w_data_a  (o_wb_data_a), .i_w_data_b  (o_wb_data_b),
      .i_rs_data_a (x_rs_data_a), .i_rt_data_a (x_rt_data_a),
      .i_rs_data_b (x_rs_data_b), .i_rt_data_b (x_rt_data_b),
      .o_op1_a     (op1_a),       .o_op2_a     (op2_a),
      .o_op1_b     (op1_b),       .o_op2_b     (op2_b)
   );

   lc4_alu alu_a_i (
      .i_op      (x_op_a),
      .i_a       (op1_a),
      .i_b       (op2_a),
      .i_imm     (x_imm_a),
      .i_use_imm (!x_rt_re_a),  // immediate forms never read rt
      .o_result  (alu_res_a)
   );

   lc4_alu alu_b_i (
      .i_op      (x_op_b),
      .i_a       (op1_b),
      .i_b       (op2_b),
      .i_imm     (x_imm_b),
      .i_use_imm (!x_rt_re_b),
      .o_result  (alu_res_b)
   );

endmodule

//--- lc4_issue_ctrl.sv
module lc4_issue_ctrl #(
   parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
   input  logic              gwe,
   input  logic              i_rst,
   input  lc4_pkg::word_t    i_insn_a,
   input  lc4_pkg::word_t    i_insn_b,
   output lc4_pkg::word_t    o_cur_pc,
   output logic              o_issue_a,
   output lc4_pkg::word_t    o_pc_a,
   output lc4_pkg::reg_sel_t o_rs_a,
   output lc4_pkg::reg_sel_t o_rt_a,
   output logic              o_rs_re_a,
   output logic              o_rt_re_a,
   output lc4_pkg::reg_sel_t o_rd_a,
   output logic              o_rd_we_a,
   output lc4_pkg::alu_op_e  o_alu_op_a,
   output lc4_pkg::word_t    o_imm_a,
   output logic              o_issue_b,
   output lc4_pkg::word_t    o_pc_b,
   output lc4_pkg::reg_sel_t o_rs_b,
   output lc4_pkg::reg_sel_t o_rt_b,
   output logic              o_rs_re_b,
   output logic              o_rt_re_b,
   output lc4_pkg::reg_sel_t o_rd_b,
   output logic              o_rd_we_b,
   output lc4_pkg::alu_op_e  o_alu_op_b,
   output lc4_pkg::word_t    o_imm_b
);

   lc4_pkg::word_t pc;
   lc4_pkg::word_t pc_plus_one;
   lc4_pkg::word_t d_insn_a;
   lc4_pkg::word_t d_insn_b;
   lc4_pkg::word_t d_pc_a;
   lc4_pkg::word_t d_pc_b;
   logic           d_valid;  // decode slots hold fetched words
   logic           split;

   lc4_decoder dec_a_i (
      .i_insn   (d_insn_a),
      .o_rs     (o_rs_a),
      .o_rt     (o_rt_a),
      .o_rd     (o_rd_a),
      .o_rs_re  (o_rs_re_a),
      .o_rt_re  (o_rt_re_a),
      .o_rd_we  (o_rd_we_a),
      .o_alu_op (o_alu_op_a),
      .o_imm    (o_imm_a)
   );

   lc4_decoder dec_b_i (
      .i_insn   (d_insn_b),
      .o_rs     (o_rs_b),
      .o_rt     (o_rt_b),
      .o_rd     (o_rd_b),
      .o_rs_re  (o_rs_re_b),
      .o_rt_re  (o_rt_re_b),
      .o_rd_we  (o_rd_we_b),
      .o_alu_op (o_alu_op_b),
      .o_imm    (o_imm_b)
   );

   // slot b depends on slot a within the pair
   assign split = o_rd_we_a && ((o_rs_re_b && o_rs_b == o_rd_a) ||
                                (o_rt_re_b && o_rt_b == o_rd_a));

   assign pc_plus_one = pc + 16'd1;

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc       <= RESET_PC;
         d_insn_a <= lc4_pkg::NOP_INSN;
         d_insn_b <= lc4_pkg::NOP_INSN;
         d_valid  <= 1'b0;
      end else if (split) begin
         pc       <= pc_plus_one;
         d_insn_a <= d_insn_b;  // held back one cycle
         d_insn_b <= i_insn_a;
         d_valid  <= 1'b1;
      end else begin
         pc       <= pc + 16'd2;
         d_insn_a <= i_insn_a;
         d_insn_b <= i_insn_b;
         d_valid  <= 1'b1;
      end
   end

   // pc of each slot follows its instruction
   always_ff @(posedge gwe) begin
      if (split) begin
         d_pc_a <= d_pc_b;
         d_pc_b <= pc;
      end else begin
         d_pc_a <= pc;
         d_pc_b <= pc_plus_one;
      end
   end

   assign o_cur_pc  = pc;
   assign o_pc_a    = d_pc_a;
   assign o_pc_b    = d_pc_b;
   assign o_issue_a = d_valid;
   assign o_issue_b = d_valid && !split;  // bubble in lane b on a split

endmodule

//--- lc4_pkg.sv
package lc4_pkg;

   typedef logic [15:0] word_t;     // data, pc or instruction
   typedef logic [2:0]  reg_sel_t;  // register number

   localparam int NUM_REGS = 8;

   // major opcode, insn[15:12]
   typedef enum logic [3:0] {
      OP_NOP   = 4'b0000,
      OP_ARITH = 4'b0001,  // ADD, SUB, ADD imm
      OP_LOGIC = 4'b0101,  // AND, OR, AND imm
      OP_CONST = 4'b1001
   } opcode_e;

   // operation performed by one lane
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_PASS_IMM  // CONST
   } alu_op_e;

   // all zero, writes nothing
   localparam word_t NOP_INSN = 16'h0000;

endpackage

//--- lc4_regfile_dual.sv
module lc4_regfile_dual (
   input  logic              gwe,
   input  logic              i_rst,
   input  lc4_pkg::reg_sel_t i_rs_a,
   input  lc4_pkg::reg_sel_t i_rt_a,
   input  lc4_pkg::reg_sel_t i_rs_b,
   input  lc4_pkg::reg_sel_t i_rt_b,
   output lc4_pkg::word_t    o_rs_data_a,
   output lc4_pkg::word_t    o_rt_data_a,
   output lc4_pkg::word_t    o_rs_data_b,
   output lc4_pkg::word_t    o_rt_data_b,
   input  lc4_pkg::reg_sel_t i_rd_a,
   input  lc4_pkg::word_t    i_wdata_a,
   input  logic              i_we_a,
   input  lc4_pkg::reg_sel_t i_rd_b,
   input  lc4_pkg::word_t    i_wdata_b,
   input  logic              i_we_b
);

   lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

   // same-cycle write shows up on the read, lane b first
   function automatic lc4_pkg::word_t rd_fwd(input lc4_pkg::reg_sel_t sel);
      if (i_we_b && i_rd_b == sel) return i_wdata_b;
      if (i_we_a && i_rd_a == sel) return i_wdata_a;
      return regs[sel];
   endfunction

   always_comb begin
      o_rs_data_a = rd_fwd(i_rs_a);
      o_rt_data_a = rd_fwd(i_rt_a);
      o_rs_data_b = rd_fwd(i_rs_b);
      o_rt_data_b = rd_fwd(i_rt_b);
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (i_we_a) regs[i_rd_a] <= i_wdata_a;
         if (i_we_b) regs[i_rd_b] <= i_wdata_b;  // later write, b wins on a tie
      end
   end

endmodule

//--- lc4_superscalar.sv
module lc4_superscalar #(
   parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
   input  logic              gwe,
   input  logic              i_rst,
   output lc4_pkg::word_t    o_cur_pc,
   input  lc4_pkg::word_t    i_insn_a,
   input  lc4_pkg::word_t    i_insn_b,
   output logic              o_wb_we_a,
   output lc4_pkg::reg_sel_t o_wb_rd_a,
   output lc4_pkg::word_t    o_wb_data_a,
   output lc4_pkg::word_t    o_wb_pc_a,
   output logic              o_wb_we_b,
   output lc4_pkg::reg_sel_t o_wb_rd_b,
   output lc4_pkg::word_t    o_wb_data_b,
   output lc4_pkg::word_t    o_wb_pc_b
);

   logic              issue_a, issue_b;
   logic              rs_re_a, rt_re_a, rd_we_a, rs_re_b, rt_re_b, rd_we_b;
   lc4_pkg::reg_sel_t rs_a, rt_a, rd_a, rs_b, rt_b, rd_b;
   lc4_pkg::alu_op_e  alu_op_a, alu_op_b;
   lc4_pkg::word_t    pc_a, imm_a, pc_b, imm_b;
   lc4_pkg::word_t    rs_data_a, rt_data_a, rs_data_b, rt_data_b;

   lc4_issue_ctrl #(.RESET_PC(RESET_PC)) issue_i (
      .gwe        (gwe),      .i_rst      (i_rst),
      .i_insn_a   (i_insn_a), .i_insn_b   (i_insn_b),
      .o_cur_pc   (o_cur_pc),
      .o_issue_a  (issue_a),  .o_pc_a     (pc_a),
      .o_rs_a     (rs_a),     .o_rt_a     (rt_a),
      .o_rs_re_a  (rs_re_a),  .o_rt_re_a  (rt_re_a),
      .o_rd_a     (rd_a),     .o_rd_we_a  (rd_we_a),
      .o_alu_op_a (alu_op_a), .o_imm_a    (imm_a),
      .o_issue_b  (issue_b),  .o_pc_b     (pc_b),
      .o_rs_b     (rs_b),     .o_rt_b     (rt_b),
      .o_rs_re_b  (rs_re_b),  .o_rt_re_b  (rt_re_b),
      .o_rd_b     (rd_b),     .o_rd_we_b  (rd_we_b),
      .o_alu_op_b (alu_op_b), .o_imm_b    (imm_b)
   );

   // read in decode, written from W
   lc4_regfile_dual regfile_i (
      .gwe         (gwe),       .i_rst       (i_rst),
      .i_rs_a      (rs_a),      .i_rt_a      (rt_a),
      .i_rs_b      (rs_b),      .i_rt_b      (rt_b),
      .o_rs_data_a (rs_data_a), .o_rt_data_a (rt_data_a),
      .o_rs_data_b (rs_data_b), .o_rt_data_b (rt_data_b),
      .i_rd_a      (o_wb_rd_a), .i_wdata_a   (o_wb_data_a), .i_we_a (o_wb_we_a),
      .i_rd_b      (o_wb_rd_b), .i_wdata_b   (o_wb_data_b), .i_we_b (o_wb_we_b)
   );

   lc4_exec_pipe exec_i (
      .gwe         (gwe),         .i_rst       (i_rst),
      .i_issue_a   (issue_a),     .i_pc_a      (pc_a),
      .i_rs_a      (rs_a),        .i_rt_a      (rt_a),
      .i_rs_re_a   (rs_re_a),     .i_rt_re_a   (rt_re_a),
      .i_rd_a      (rd_a),        .i_rd_we_a   (rd_we_a),
      .i_alu_op_a  (alu_op_a),    .i_imm_a     (imm_a),
      .i_issue_b   (issue_b),     .i_pc_b      (pc_b),
      .i_rs_b      (rs_b),        .i_rt_b      (rt_b),
      .i_rs_re_b   (rs_re_b),     .i_rt_re_b   (rt_re_b),
      .i_rd_b      (rd_b),        .i_rd_we_b   (rd_we_b),
      .i_alu_op_b  (alu_op_b),    .i_imm_b     (imm_b),
      .i_rs_data_a (rs_data_a),   .i_rt_data_a (rt_data_a),
      .i_rs_data_b (rs_data_b),   .i_rt_data_b (rt_data_b),
      .o_wb_we_a   (o_wb_we_a),   .o_wb_rd_a   (o_wb_rd_a),
      .o_wb_data_a (o_wb_data_a), .o_wb_pc_a   (o_wb_pc_a),
      .o_wb_we_b   (o_wb_we_b),   .o_wb_rd_b   (o_wb_rd_b),
      .o_wb_data_b (o_wb_data_b), .o_wb_pc_b   (o_wb_pc_b)
   );

endmodule

//--- tb_clock.sv
module tb_clock #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 3
) (
   output logic o_clk,
   output logic o_rst
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   initial begin
      o_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst <= 1'b0;  // released on a falling edge
   end

endmodule

//--- tb_lc4_superscalar.sv
module tb_lc4_superscalar;
   timeunit 1ns;
   timeprecision 100ps;

   localparam lc4_pkg::word_t RESET_PC = 16'h8200;
   localparam int RESET_LIMIT  = 20;   // cycles
   localparam int RETIRE_LIMIT = 200;

   logic              gwe;
   logic              rst;
   lc4_pkg::word_t    cur_pc;
   lc4_pkg::word_t    insn_a, insn_b;
   logic              wb_we_a, wb_we_b;
   lc4_pkg::reg_sel_t wb_rd_a, wb_rd_b;
   lc4_pkg::word_t    wb_data_a, wb_data_b, wb_pc_a, wb_pc_b;

   lc4_pkg::word_t    prog_addr [$];  // program words and their addresses
   lc4_pkg::word_t    prog_word [$];
   lc4_pkg::word_t    exp_pc [$];
   lc4_pkg::reg_sel_t exp_rd [$];
   lc4_pkg::word_t    exp_data [$];
   logic              exp_same [$];
   lc4_pkg::word_t    prev_pc;
   lc4_pkg::word_t    step_hist [3];  // pc steps of the last three edges with the newest first
   int                cyc;
   int                last_cyc;
   int                guard;

   tb_clock #(.PERIOD_NS(40), .RST_CYCLES(3)) clock_i (.o_clk(gwe), .o_rst(rst));

   lc4_superscalar #(.RESET_PC(RESET_PC)) dut_i (
      .gwe         (gwe),       .i_rst       (rst),
      .o_cur_pc    (cur_pc),
      .i_insn_a    (insn_a),    .i_insn_b    (insn_b),
      .o_wb_we_a   (wb_we_a),   .o_wb_rd_a   (wb_rd_a),
      .o_wb_data_a (wb_data_a), .o_wb_pc_a   (wb_pc_a),
      .o_wb_we_b   (wb_we_b),   .o_wb_rd_b   (wb_rd_b),
      .o_wb_data_b (wb_data_b), .o_wb_pc_b   (wb_pc_b)
   );

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input lc4_pkg::word_t got,
                             input lc4_pkg::word_t exp);
      if (got !== exp) stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_reg(input string name, input lc4_pkg::reg_sel_t got,
                            input lc4_pkg::reg_sel_t exp);
      if (got !== exp) stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
   endtask

   function automatic lc4_pkg::word_t fetch(input lc4_pkg::word_t addr);
      for (int i = 0; i < prog_addr.size(); i++) begin
         if (prog_addr[i] == addr) return prog_word[i];
      end
      return lc4_pkg::NOP_INSN;  // nothing beyond the program
   endfunction

   task automatic load_cases();
      int          fd;
      int          n;
      string       line;
      byte         tag;
      logic [15:0] f1, f2, f3, f4;
      fd = $fopen("lc4_cases.txt", "r");
      if (fd == 0) stop_run("could not open lc4_cases.txt");
      while ($fgets(line, fd) != 0) begin
         tag = 0;
         n = $sscanf(line, "%c %h %h %h %h", tag, f1, f2, f3, f4);
         if (tag == "P" && n == 3) begin
            prog_addr.push_back(f1);
            prog_word.push_back(f2);
         end else if (tag == "E" && n == 5) begin
            exp_pc.push_back(f1);
            exp_rd.push_back(f2[2:0]);
            exp_data.push_back(f3);
            exp_same.push_back(f4[0]);
         end else if (tag == "P" || tag == "E") begin
            stop_run($sformatf("malformed line in lc4_cases.txt: %s", line));
         end
      end
      $fclose(fd);
      if (exp_pc.size() == 0) stop_run("lc4_cases.txt lists no expected retirements");
   endtask

   // inputs change on the falling edge only
   task automatic next_cycle();
      @(negedge gwe);
      insn_a = fetch(cur_pc);
      insn_b = fetch(cur_pc + 16'd1);
   endtask

   task automatic track_pc();
      lc4_pkg::word_t step;
      step = cur_pc - prev_pc;
      if (step != 16'd1 && step != 16'd2)
         stop_run($sformatf("o_cur_pc jumped from %h to %h", prev_pc, cur_pc));
      step_hist[2] = step_hist[1];
      step_hist[1] = step_hist[0];
      step_hist[0] = step;
      prev_pc = cur_pc;
   endtask

   task automatic retire_one(input logic lane_b, input lc4_pkg::word_t pc,
                             input lc4_pkg::reg_sel_t rd, input lc4_pkg::word_t data);
      if (exp_pc.size() == 0) begin
         stop_run($sformatf("unexpected retire of pc %h in lane %s", pc, lane_b ? "b" : "a"));
      end else begin
         check_word(lane_b ? "o_wb_pc_b" : "o_wb_pc_a", pc, exp_pc[0]);
         check_reg(lane_b ? "o_wb_rd_b" : "o_wb_rd_a", rd, exp_rd[0]);
         check_word(lane_b ? "o_wb_data_b" : "o_wb_data_a", data, exp_data[0]);
         check_bit("retire lane b", lane_b, exp_same[0]);  // second of a pair sits in b
         check_bit("same cycle retire", cyc == last_cyc, exp_same[0]);
         last_cyc = cyc;
         void'(exp_pc.pop_front());
         void'(exp_rd.pop_front());
         void'(exp_data.pop_front());
         void'(exp_same.pop_front());
      end
   endtask

   // lane a before lane b gives program order
   task automatic watch_retires();
      if (wb_we_a) retire_one(1'b0, wb_pc_a, wb_rd_a, wb_data_a);
      if (wb_we_b) retire_one(1'b1, wb_pc_b, wb_rd_b, wb_data_b);
      // this pair left decode two edges back
      if (wb_we_b)
         check_word("o_cur_pc step", step_hist[2], 16'd2);
      else if (wb_we_a && exp_pc.size() > 0)
         check_word("o_cur_pc step", step_hist[2], 16'd1);  // split pair
      cyc++;
   endtask

   initial begin
      insn_a   = lc4_pkg::NOP_INSN;
      insn_b   = lc4_pkg::NOP_INSN;
      cyc      = 0;
      last_cyc = -1;
      load_cases();
      @(posedge gwe);
      next_cycle();
      guard = 0;
      while (rst) begin
         check_bit("o_wb_we_a", wb_we_a, 1'b0);
         check_bit("o_wb_we_b", wb_we_b, 1'b0);
         check_word("o_cur_pc", cur_pc, RESET_PC);
         prev_pc = cur_pc;
         guard++;
         if (guard > RESET_LIMIT) stop_run("timed out waiting for reset to be released");
         next_cycle();
      end
      guard = 0;
      while (exp_pc.size() > 0) begin
         track_pc();
         watch_retires();
         guard++;
         if (guard > RETIRE_LIMIT) stop_run("timed out waiting for the expected retires");
         next_cycle();
      end
      repeat (8) begin  // only nops follow so nothing may retire
         track_pc();
         watch_retires();
         next_cycle();
      end
      $display("all tests passed");
      $finish;
   end

endmodule
